// ==== rsp_s2_config.svh ====
`ifndef RSP_S2_CONFIG_SVH
`define RSP_S2_CONFIG_SVH

//////////////////////////////
// Phase RAM geometry
//////////////////////////////
`define RSP_S2_PHASE_DEPTH    64
`define RSP_S2_PHASE_DW       32

//////////////////////////////
// DC estimation datapath
//////////////////////////////
`define RSP_S2_ACC_W          48
`define RSP_S2_SCALE_W        17
`define RSP_S2_SCALE_SHIFT    16    // 65536 is unity gain
`define RSP_S2_FRM_W          4

//////////////////////////////
// Wishbone register map
//////////////////////////////
`define RSP_S2_WB_AW          12
`define RSP_S2_ADDR_DC_SCALE  12'h000
`define RSP_S2_ADDR_STATUS    12'h004
`define RSP_S2_ADDR_RAM_BASE  12'h100 // Window of 4 bytes per entry

`endif

// ==== rsp_s2_pkg.sv ====
`include "rsp_s2_config.svh"

package rsp_s2_pkg;

  // Plain vectors
  typedef logic [$clog2(`RSP_S2_PHASE_DEPTH)-1:0] phase_idx_t;
  typedef logic [`RSP_S2_PHASE_DW-1:0]            phase_data_t; // Signed in the core
  typedef logic [$clog2(`RSP_S2_PHASE_DEPTH):0]   entry_cnt_t;  // 1 to 64
  typedef logic [`RSP_S2_SCALE_W-1:0]             dc_scale_t;
  typedef logic [`RSP_S2_FRM_W-1:0]               frame_id_t;
  typedef logic [`RSP_S2_WB_AW-1:0]               wb_addr_t;
  typedef logic [31:0]                            wb_data_t;

  //////////////////////////////
  // Operation handshakes
  //////////////////////////////
  typedef struct packed {
    phase_idx_t base_idx;
    entry_cnt_t entry_num;
  } cmd_info_t;

  typedef struct packed {
    logic      ping_pong;
    frame_id_t frame_type_id;
  } start_info_t;

  typedef struct packed {
    frame_id_t   frame_type_id;
    phase_data_t dc_result;
  } finish_info_t;

  typedef struct packed {
    phase_idx_t start_idx;
    entry_cnt_t entry_num;
    frame_id_t  frame_type_id;
  } core_job_t;

  //////////////////////////////
  // Phase RAM ports
  //////////////////////////////
  typedef struct packed {
    logic        req;
    logic        we;
    phase_idx_t  idx;
    phase_data_t wdata;
  } ram_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvld;
    phase_data_t rdata;
  } ram_rsp_t;

  // Wishbone classic
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ARMED,
    ST_RUN,
    ST_FINISH
  } op_state_t;

endpackage

// ==== rsp_s2_wb_regs.sv ====
`include "rsp_s2_config.svh"

module rsp_s2_wb_regs (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  rsp_s2_pkg::wb_req_t     i_wb,
  output rsp_s2_pkg::wb_rsp_t     o_wb,
  output rsp_s2_pkg::ram_req_t    o_ram_req,
  input  rsp_s2_pkg::ram_rsp_t    i_ram_rsp,
  output rsp_s2_pkg::dc_scale_t   o_dc_scale,
  input  rsp_s2_pkg::phase_data_t i_dc_result,
  input  logic                    i_result_vld
);

  import rsp_s2_pkg::*;

  localparam int WIN_BYTES = `RSP_S2_PHASE_DEPTH * 4;

  logic        cyc_stb;
  wb_addr_t    win_off;
  logic        win_hit;
  logic        busy;
  logic        ack_q;
  wb_data_t    rdat_q;
  dc_scale_t   dc_scale_q;
  phase_data_t status_q;
  logic        req_q;
  logic        req_we_q;
  phase_idx_t  req_idx_q;
  phase_data_t req_wdata_q;

  assign cyc_stb = i_wb.cyc & i_wb.stb;
  assign win_off = i_wb.adr - `RSP_S2_ADDR_RAM_BASE;
  assign win_hit = (i_wb.adr >= `RSP_S2_ADDR_RAM_BASE) && (win_off < WIN_BYTES);

  // Access in flight or being acked, master still holds stb
  assign busy = req_q | ack_q | i_ram_rsp.rvld;

  //////////////////////////////
  // Control and registers
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ack_q      <= 1'b0;
      req_q      <= 1'b0;
      dc_scale_q <= dc_scale_t'(1 << `RSP_S2_SCALE_SHIFT);
      status_q   <= '0;
    end else begin
      ack_q <= 1'b0;
      if (cyc_stb && !busy && !win_hit) begin
        ack_q <= 1'b1;                                // Register or unmapped
        if (i_wb.we && (i_wb.adr == `RSP_S2_ADDR_DC_SCALE)) begin
          dc_scale_q <= i_wb.dat[`RSP_S2_SCALE_W-1:0];
        end
      end
      if (cyc_stb && !busy && win_hit) begin
        req_q <= 1'b1;
      end else if (i_ram_rsp.gnt) begin
        req_q <= 1'b0;
        ack_q <= req_we_q;                            // Reads ack on rvld
      end
      if (i_result_vld) begin
        status_q <= i_dc_result;
      end
    end
  end

  // Request payload and register read data
  always_ff @(posedge i_clk) begin
    if (cyc_stb && !busy) begin
      req_we_q    <= i_wb.we;
      req_idx_q   <= win_off[2 +: $bits(phase_idx_t)];  // Byte to entry
      req_wdata_q <= i_wb.dat;
      case (i_wb.adr)
        `RSP_S2_ADDR_DC_SCALE: rdat_q <= wb_data_t'(dc_scale_q);
        `RSP_S2_ADDR_STATUS:   rdat_q <= status_q;
        default:               rdat_q <= '0;
      endcase
    end
  end

  assign o_wb.ack = ack_q | i_ram_rsp.rvld;
  assign o_wb.dat = i_ram_rsp.rvld ? i_ram_rsp.rdata : rdat_q;

  assign o_ram_req.req   = req_q;
  assign o_ram_req.we    = req_we_q;
  assign o_ram_req.idx   = req_idx_q;
  assign o_ram_req.wdata = req_wdata_q;

  assign o_dc_scale = dc_scale_q;

endmodule

// ==== rsp_s2_phase_ram.sv ====
`include "rsp_s2_config.svh"

module rsp_s2_phase_ram (
  input  logic                 i_clk,
  input  logic                 i_rst,
  input  rsp_s2_pkg::ram_req_t i_bus_req,
  output rsp_s2_pkg::ram_rsp_t o_bus_rsp,
  input  rsp_s2_pkg::ram_req_t i_core_req,
  output rsp_s2_pkg::ram_rsp_t o_core_rsp
);

  import rsp_s2_pkg::*;

  phase_data_t mem [`RSP_S2_PHASE_DEPTH];
  logic        gnt_bus;
  logic        gnt_core;
  ram_req_t    sel;
  phase_data_t rdata_q;
  logic        rvld_bus_q;
  logic        rvld_core_q;

  //////////////////////////////
  // Fixed priority arbiter
  //////////////////////////////
  assign gnt_bus  = i_bus_req.req;                    // Bus port always wins
  assign gnt_core = i_core_req.req & ~i_bus_req.req;
  assign sel      = gnt_bus ? i_bus_req : i_core_req;

  // Storage, one access per cycle
  always_ff @(posedge i_clk) begin
    if (sel.req) begin
      if (sel.we) begin
        mem[sel.idx] <= sel.wdata;
      end else begin
        rdata_q <= mem[sel.idx];
      end
    end
  end

  // Read valid follows the grant by one cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rvld_bus_q  <= 1'b0;
      rvld_core_q <= 1'b0;
    end else begin
      rvld_bus_q  <= gnt_bus & ~i_bus_req.we;
      rvld_core_q <= gnt_core & ~i_core_req.we;
    end
  end

  assign o_bus_rsp.gnt   = gnt_bus;
  assign o_bus_rsp.rvld  = rvld_bus_q;
  assign o_bus_rsp.rdata = rdata_q;

  assign o_core_rsp.gnt   = gnt_core;
  assign o_core_rsp.rvld  = rvld_core_q;
  assign o_core_rsp.rdata = rdata_q;          // Shared, rvld tells the owner

endmodule

// ==== rsp_s2_op_fsm.sv ====
module rsp_s2_op_fsm (
  input  logic                     i_clk,
  input  logic                     i_rst,
  // Command handshake
  input  logic                     i_cmd_req,
  input  rsp_s2_pkg::cmd_info_t    i_cmd_info,
  output logic                     o_cmd_ack,
  // Start handshake
  input  logic                     i_start_req,
  input  rsp_s2_pkg::start_info_t  i_start_info,
  output logic                     o_start_ack,
  // Finish handshake
  output logic                     o_finish_req,
  output rsp_s2_pkg::finish_info_t o_finish_info,
  input  logic                     i_finish_ack,
  // Core
  output logic                     o_core_start,
  output rsp_s2_pkg::core_job_t    o_core_job,
  input  logic                     i_core_done,
  input  rsp_s2_pkg::phase_data_t  i_dc_result
);

  import rsp_s2_pkg::*;

  op_state_t  state_q;
  cmd_info_t  cmd_q;
  phase_idx_t pp_idx;
  logic       cmd_take;
  logic       start_take;

  // Ack guard stops a held command from being taken twice
  assign start_take = i_start_req & (state_q == ST_ARMED);
  assign cmd_take   = i_cmd_req & ~o_cmd_ack & ~start_take &
                      ((state_q == ST_IDLE) || (state_q == ST_ARMED));

  // Pong half starts right after the ping range mod 64
  assign pp_idx = cmd_q.base_idx + phase_idx_t'(cmd_q.entry_num);

  //////////////////////////////
  // State machine
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q      <= ST_IDLE;
      o_cmd_ack    <= 1'b0;
      o_start_ack  <= 1'b0;
      o_core_start <= 1'b0;
      o_finish_req <= 1'b0;
    end else begin
      o_cmd_ack    <= cmd_take;
      o_start_ack  <= start_take;
      o_core_start <= start_take;              // Same cycle as start ack
      case (state_q)
        ST_IDLE: begin
          if (cmd_take) begin
            state_q <= ST_ARMED;
          end
        end
        ST_ARMED: begin
          if (start_take) begin
            state_q <= ST_RUN;
          end
        end
        ST_RUN: begin
          if (i_core_done) begin
            state_q      <= ST_FINISH;
            o_finish_req <= 1'b1;
          end
        end
        ST_FINISH: begin
          if (i_finish_ack) begin
            state_q      <= ST_ARMED;          // Command stays armed
            o_finish_req <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // Command, job and finish payload
  always_ff @(posedge i_clk) begin
    if (cmd_take) begin
      cmd_q <= i_cmd_info;
    end
    if (start_take) begin
      o_core_job.start_idx     <= i_start_info.ping_pong ? pp_idx : cmd_q.base_idx;
      o_core_job.entry_num     <= cmd_q.entry_num;
      o_core_job.frame_type_id <= i_start_info.frame_type_id;
    end
    if ((state_q == ST_RUN) && i_core_done) begin
      o_finish_info.frame_type_id <= o_core_job.frame_type_id;
      o_finish_info.dc_result     <= i_dc_result;  // Held until ack
    end
  end

endmodule

// ==== rsp_s2_prep_core.sv ====
`include "rsp_s2_config.svh"

module rsp_s2_prep_core (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_start,
  input  rsp_s2_pkg::core_job_t   i_job,
  input  rsp_s2_pkg::dc_scale_t   i_dc_scale,
  output rsp_s2_pkg::ram_req_t    o_ram_req,
  input  rsp_s2_pkg::ram_rsp_t    i_ram_rsp,
  output logic                    o_done,
  output rsp_s2_pkg::phase_data_t o_dc_result
);

  import rsp_s2_pkg::*;

  localparam int ACC_W  = `RSP_S2_ACC_W;
  localparam int DW     = `RSP_S2_PHASE_DW;
  localparam int PROD_W = ACC_W + `RSP_S2_SCALE_W + 1;

  logic                     busy_q;
  logic                     req_q;
  logic                     fin_q;
  phase_idx_t               idx_q;
  entry_cnt_t               left_q;
  logic signed [ACC_W-1:0]  acc_q;
  logic signed [ACC_W-1:0]  word_ext;
  logic signed [PROD_W-1:0] prod;
  logic signed [PROD_W-1:0] prod_sh;

  assign word_ext = {{(ACC_W-DW){i_ram_rsp.rdata[DW-1]}}, i_ram_rsp.rdata};

  // Scale is unsigned, zero bit keeps it positive
  assign prod    = acc_q * $signed({1'b0, i_dc_scale});
  assign prod_sh = prod >>> `RSP_S2_SCALE_SHIFT;

  //////////////////////////////
  // Read sequencing
  //////////////////////////////
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
      req_q  <= 1'b0;
      fin_q  <= 1'b0;
      o_done <= 1'b0;
    end else begin
      fin_q  <= 1'b0;
      o_done <= fin_q;
      if (i_start && !busy_q) begin
        busy_q <= 1'b1;
        req_q  <= 1'b1;
      end
      if (i_ram_rsp.gnt) begin
        req_q <= 1'b0;                       // One read outstanding
      end
      if (i_ram_rsp.rvld) begin
        if (left_q == entry_cnt_t'(1)) begin
          fin_q <= 1'b1;                     // Last word in
        end else begin
          req_q <= 1'b1;
        end
      end
      if (fin_q) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Accumulate and scale
  always_ff @(posedge i_clk) begin
    if (i_start && !busy_q) begin
      idx_q  <= i_job.start_idx;
      left_q <= i_job.entry_num;
      acc_q  <= '0;
    end else if (i_ram_rsp.rvld) begin
      idx_q  <= idx_q + 1'b1;                // Wraps past 63
      left_q <= left_q - 1'b1;
      acc_q  <= acc_q + word_ext;
    end
    if (fin_q) begin
      o_dc_result <= prod_sh[DW-1:0];
    end
  end

  assign o_ram_req.req   = req_q;
  assign o_ram_req.we    = 1'b0;             // Core only reads
  assign o_ram_req.idx   = idx_q;
  assign o_ram_req.wdata = '0;

endmodule

// ==== rsp_s2_prep.sv ====
module rsp_s2_prep (
  input  logic                     i_clk,
  input  logic                     i_rst,
  // Configuration bus
  input  rsp_s2_pkg::wb_req_t      i_wb,
  output rsp_s2_pkg::wb_rsp_t      o_wb,
  // Command handshake
  input  logic                     i_cmd_req,
  input  rsp_s2_pkg::cmd_info_t    i_cmd_info,
  output logic                     o_cmd_ack,
  // Start handshake
  input  logic                     i_start_req,
  input  rsp_s2_pkg::start_info_t  i_start_info,
  output logic                     o_start_ack,
  // Finish handshake
  output logic                     o_finish_req,
  output rsp_s2_pkg::finish_info_t o_finish_info,
  input  logic                     i_finish_ack
);

  import rsp_s2_pkg::*;

  ram_req_t    bus_ram_req;
  ram_rsp_t    bus_ram_rsp;
  ram_req_t    core_ram_req;
  ram_rsp_t    core_ram_rsp;
  dc_scale_t   dc_scale;
  logic        core_start;
  core_job_t   core_job;
  logic        core_done;
  phase_data_t dc_result;

  //////////////////////////////
  // Config bus and phase RAM
  //////////////////////////////
  rsp_s2_wb_regs u_rsp_s2_wb_regs (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_wb         (i_wb),
    .o_wb         (o_wb),
    .o_ram_req    (bus_ram_req),
    .i_ram_rsp    (bus_ram_rsp),
    .o_dc_scale   (dc_scale),
    .i_dc_result  (dc_result),
    .i_result_vld (core_done)        // Status follows each result
  );

  rsp_s2_phase_ram u_rsp_s2_phase_ram (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_bus_req  (bus_ram_req),
    .o_bus_rsp  (bus_ram_rsp),
    .i_core_req (core_ram_req),
    .o_core_rsp (core_ram_rsp)
  );

  //////////////////////////////
  // Control and core
  //////////////////////////////
  rsp_s2_op_fsm u_rsp_s2_op_fsm (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_cmd_req     (i_cmd_req),
    .i_cmd_info    (i_cmd_info),
    .o_cmd_ack     (o_cmd_ack),
    .i_start_req   (i_start_req),
    .i_start_info  (i_start_info),
    .o_start_ack   (o_start_ack),
    .o_finish_req  (o_finish_req),
    .o_finish_info (o_finish_info),
    .i_finish_ack  (i_finish_ack),
    .o_core_start  (core_start),
    .o_core_job    (core_job),
    .i_core_done   (core_done),
    .i_dc_result   (dc_result)
  );

  rsp_s2_prep_core u_rsp_s2_prep_core (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (core_start),
    .i_job       (core_job),
    .i_dc_scale  (dc_scale),
    .o_ram_req   (core_ram_req),
    .i_ram_rsp   (core_ram_rsp),
    .o_done      (core_done),
    .o_dc_result (dc_result)
  );

endmodule

// ==== tb_rsp_s2_prep.sv ====
`include "rsp_s2_config.svh"

module tb_rsp_s2_prep;

  timeunit 1ns;
  timeprecision 1ps;

  import rsp_s2_pkg::*;

  localparam int          DEPTH      = `RSP_S2_PHASE_DEPTH;
  localparam int          SHIFT      = `RSP_S2_SCALE_SHIFT;
  localparam logic [31:0] SEED       = 32'he40fc8a5;
  // About 3000 cycles of traffic in all tests, so this leaves wide margin
  localparam int          MAX_CYCLES = 20000;

  logic         clk = 1'b0;
  logic         rst;
  wb_req_t      wb_req;
  wb_rsp_t      wb_rsp;
  logic         cmd_req;
  cmd_info_t    cmd_info;
  logic         cmd_ack;
  logic         start_req;
  start_info_t  start_info;
  logic         start_ack;
  logic         finish_req;
  finish_info_t finish_info;
  logic         finish_ack;

  phase_data_t  ram_model [DEPTH];
  dc_scale_t    scale_model;
  phase_idx_t   armed_base;
  entry_cnt_t   armed_num;
  phase_data_t  last_result;
  finish_info_t exp_q [$];
  finish_info_t exp_info;
  finish_info_t held_info;
  logic         prev_req;
  logic         prev_ack;
  int           err_cnt;
  int           chk_cnt;
  int           test_err_base;
  int           cycle_cnt;

  rsp_s2_prep i_dut (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_wb          (wb_req),
    .o_wb          (wb_rsp),
    .i_cmd_req     (cmd_req),
    .i_cmd_info    (cmd_info),
    .o_cmd_ack     (cmd_ack),
    .i_start_req   (start_req),
    .i_start_info  (start_info),
    .o_start_ack   (start_ack),
    .o_finish_req  (finish_req),
    .o_finish_info (finish_info),
    .i_finish_ack  (finish_ack)
  );

  always #10 clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the run did not complete within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic phase_data_t dc_ref(input phase_idx_t start, input entry_cnt_t num,
                                         input dc_scale_t scale);
    logic signed [47:0] sum;
    longint             prod;
    phase_idx_t         idx;
    int                 i;
    sum = '0;
    idx = start;
    for (i = 0; i < num; i++) begin
      sum = sum + $signed(ram_model[idx]);  // Sign extended to 48 bits
      idx = idx + 1'b1;                      // Wraps past 63
    end
    prod = longint'(sum) * longint'(scale);
    prod = prod >>> SHIFT;
    return prod[31:0];
  endfunction

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    assert (got == exp) else begin
      err_cnt++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    $display("%-34s %s (%0d errors)", name, (err_cnt == test_err_base) ? "ok" : "failed",
             err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  //////////////////////////////
  // Bus and handshake tasks
  //////////////////////////////
  task automatic wb_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                          output wb_data_t rdat);
    @(posedge clk);
    wb_req.cyc <= 1'b1;
    wb_req.stb <= 1'b1;
    wb_req.we  <= we;
    wb_req.adr <= adr;
    wb_req.dat <= wdat;
    do @(negedge clk); while (!wb_rsp.ack);    // Latency varies with arbitration
    rdat = wb_rsp.dat;
    @(posedge clk);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    wb_req.we  <= 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    wb_cycle(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t dat);
    wb_cycle(1'b0, adr, '0, dat);
  endtask

  task automatic set_scale();
    wb_data_t val;
    val = $urandom;
    scale_model = val[`RSP_S2_SCALE_W-1:0];
    wb_write(`RSP_S2_ADDR_DC_SCALE, val);
  endtask

  task automatic send_cmd(input phase_idx_t base, input entry_cnt_t num);
    @(posedge clk);
    cmd_req            <= 1'b1;
    cmd_info.base_idx  <= base;
    cmd_info.entry_num <= num;
    do @(negedge clk); while (!cmd_ack);
    @(posedge clk);
    cmd_req <= 1'b0;
    armed_base = base;
    armed_num  = num;
  endtask

  task automatic send_start(input logic pp, input frame_id_t frm);
    finish_info_t exp;
    phase_idx_t   idx;
    // Pong half begins right after the ping range
    idx = pp ? phase_idx_t'((int'(armed_base) + int'(armed_num)) % DEPTH) : armed_base;
    exp.frame_type_id = frm;
    exp.dc_result     = dc_ref(idx, armed_num, scale_model);
    exp_q.push_back(exp);
    last_result = exp.dc_result;
    @(posedge clk);
    start_req                <= 1'b1;
    start_info.ping_pong     <= pp;
    start_info.frame_type_id <= frm;
    do @(negedge clk); while (!start_ack);
    @(posedge clk);
    start_req <= 1'b0;
  endtask

  task automatic ack_finish(input int delay);
    do @(negedge clk); while (!finish_req);
    repeat (delay) @(negedge clk);             // Back-pressure
    @(posedge clk);
    finish_ack <= 1'b1;
    @(posedge clk);
    finish_ack <= 1'b0;
  endtask

  task automatic check_status();
    wb_data_t rdat;
    wb_read(`RSP_S2_ADDR_STATUS, rdat);
    check_value("status", rdat, last_result);
  endtask

  task automatic run_job(input phase_idx_t base, input entry_cnt_t num, input logic pp);
    set_scale();
    send_cmd(base, num);
    send_start(pp, frame_id_t'($urandom));
    ack_finish($urandom_range(12, 0));
    check_status();
  endtask

  //////////////////////////////
  // Finish compare
  //////////////////////////////
  always @(negedge clk) begin
    if (!rst) begin
      if (finish_req && !prev_req) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("Finish request raised with no job outstanding");
        end else begin
          exp_info  = exp_q.pop_front();
          held_info = finish_info;
          chk_cnt   = chk_cnt + 2;
          assert (finish_info.frame_type_id == exp_info.frame_type_id) else begin
            err_cnt++;
            $display("** Error: o_finish_info.frame_type_id = 0x%0h, expected 0x%0h",
                     finish_info.frame_type_id, exp_info.frame_type_id);
          end
          assert (finish_info.dc_result == exp_info.dc_result) else begin
            err_cnt++;
            $display("** Error: o_finish_info.dc_result = 0x%0h, expected 0x%0h",
                     finish_info.dc_result, exp_info.dc_result);
          end
        end
      end else if (finish_req && prev_req) begin
        chk_cnt++;
        assert (finish_info == held_info) else begin  // Must hold until ack
          err_cnt++;
          $display("** Error: o_finish_info = 0x%0h, expected 0x%0h", finish_info, held_info);
        end
      end else if (!finish_req && prev_req) begin
        chk_cnt++;
        assert (prev_ack) else begin
          err_cnt++;
          $display("Finish request dropped before the finish ack was given");
        end
      end
    end
    prev_req = finish_req;
    prev_ack = finish_ack;
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////
  initial begin
    wb_data_t rdat;
    wb_data_t val;
    int       i;
    int       idx;
    void'($urandom(SEED));
    err_cnt       = 0;
    chk_cnt       = 0;
    test_err_base = 0;
    cycle_cnt     = 0;
    prev_req      = 1'b0;
    prev_ack      = 1'b0;
    rst        <= 1'b1;
    wb_req     <= '0;
    cmd_req    <= 1'b0;
    cmd_info   <= '0;
    start_req  <= 1'b0;
    start_info <= '0;
    finish_ack <= 1'b0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // Reset values
    check_value("o_cmd_ack", cmd_ack, 0);
    check_value("o_start_ack", start_ack, 0);
    check_value("o_finish_req", finish_req, 0);
    check_value("o_wb.ack", wb_rsp.ack, 0);
    wb_read(`RSP_S2_ADDR_DC_SCALE, rdat);
    check_value("dc_scale", rdat, 32'd65536);
    wb_read(`RSP_S2_ADDR_STATUS, rdat);
    check_value("status", rdat, 0);
    scale_model = 17'd65536;
    end_test("1 reset values");

    // Registers and unmapped space
    val = $urandom;
    wb_write(`RSP_S2_ADDR_DC_SCALE, val);
    scale_model = val[`RSP_S2_SCALE_W-1:0];
    wb_read(`RSP_S2_ADDR_DC_SCALE, rdat);
    check_value("dc_scale", rdat, {15'd0, scale_model});
    wb_write(12'h200, $urandom);
    wb_read(12'h200, rdat);
    check_value("unmapped 0x200", rdat, 0);
    wb_read(12'h008, rdat);
    check_value("unmapped 0x008", rdat, 0);
    end_test("2 register access");

    // Fill the phase RAM and read it back
    for (i = 0; i < DEPTH; i++) begin
      ram_model[i] = $urandom;
      wb_write(wb_addr_t'(`RSP_S2_ADDR_RAM_BASE + i * 4), ram_model[i]);
    end
    for (i = 0; i < DEPTH; i++) begin
      wb_read(wb_addr_t'(`RSP_S2_ADDR_RAM_BASE + i * 4), rdat);
      check_value($sformatf("ram[%0d]", i), rdat, ram_model[i]);
    end
    end_test("3 RAM window");

    // Two wrapping ranges first, then random ones
    run_job(6'd58, 7'd12, 1'b0);
    run_job(6'd40, 7'd20, 1'b1);
    for (i = 0; i < 6; i++) begin
      run_job(phase_idx_t'($urandom), entry_cnt_t'($urandom_range(64, 1)), i[0]);
    end
    end_test("4 jobs");

    // One command, two starts
    set_scale();
    send_cmd(phase_idx_t'($urandom), entry_cnt_t'($urandom_range(32, 1)));
    send_start(1'b0, frame_id_t'($urandom));
    ack_finish($urandom_range(20, 5));
    check_status();
    send_start(1'b1, frame_id_t'($urandom));
    ack_finish($urandom_range(20, 5));
    check_status();
    end_test("5 finish back-pressure");

    // Bus reads while the core walks all 64 entries
    set_scale();
    send_cmd(phase_idx_t'($urandom), 7'd64);
    send_start(1'($urandom), frame_id_t'($urandom));
    for (i = 0; i < 8; i++) begin
      idx = $urandom_range(DEPTH - 1, 0);
      wb_read(wb_addr_t'(`RSP_S2_ADDR_RAM_BASE + idx * 4), rdat);
      check_value($sformatf("ram[%0d]", idx), rdat, ram_model[idx]);
    end
    ack_finish($urandom_range(8, 0));
    check_status();
    end_test("6 RAM contention");

    repeat (4) @(negedge clk);
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d jobs never raised a finish request", exp_q.size());
    end
    $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+.
rsp_s2_pkg.sv
rsp_s2_wb_regs.sv
rsp_s2_phase_ram.sv
rsp_s2_op_fsm.sv
rsp_s2_prep_core.sv
rsp_s2_prep.sv
tb_rsp_s2_prep.sv
